//--- verification/trig_golden.txt
# gap trig_type chan_en acq_enable xadc_alarms rst_num rst_ts rdy_mode exp_empty exp_num exp_evt exp_err
# decimal columns; rdy_mode 0 = rec_ready high, 1 = held low, 2 = random stalls
5 4 31 1 0 0 0 0 0 1 1 0
16 4 3 1 2 0 0 0 0 2 2 0
16 4 1 1 0 0 0 0 0 3 3 0
16 1 31 1 1 0 0 0 1 4 4 0
4 4 31 0 0 0 0 0 1 5 4 0
4 4 0 1 8 0 0 0 1 6 4 0
4 2 31 1 5 0 0 0 1 7 4 0
6 4 31 1 0 1 0 0 0 1 1 0
16 4 31 1 3 0 1 0 0 2 2 0
16 3 31 1 0 1 1 0 1 1 1 0
16 1 31 1 1 0 0 1 1 2 1 0
3 1 31 1 2 0 0 1 1 3 1 0
3 1 31 1 3 0 0 1 1 4 1 0
3 1 31 1 4 0 0 1 1 5 1 0
3 1 31 1 5 0 0 1 1 6 1 0
3 1 31 1 6 0 0 1 1 7 1 0
3 1 31 1 7 0 0 1 1 8 1 0
3 1 31 1 9 0 0 1 1 9 1 0
8 2 31 1 10 0 0 2 1 10 1 0
8 2 31 1 11 0 0 2 1 11 1 0
8 2 31 1 12 0 0 2 1 12 1 0
20 4 31 1 6 0 0 0 0 13 1 0
4 4 31 1 0 0 0 0 0 14 2 1

//--- project.f
+incdir+include
hw/ttc_trig_pkg.sv
hw/ttc_trigger_receiver.sv
hw/trig_info_fifo.sv
hw/acq_channel_ctrl.sv
hw/ttc_trig_top.sv
verification/trig_checker.sv
verification/tb_top.sv

//--- Bender.yml
package:
  name: ttc_trig

export_include_dirs:
  - include

sources:
  - files:
      - hw/ttc_trig_pkg.sv
      - hw/ttc_trigger_receiver.sv
      - hw/trig_info_fifo.sv
      - hw/acq_channel_ctrl.sv
      - hw/ttc_trig_top.sv
  - target: test
    files:
      - verification/trig_checker.sv
      - verification/tb_top.sv

//--- verification/tb_top.sv
// *********************************************************************
// testbench for the TTC trigger subsystem: replays the golden file on
// falling edges, drives rec_ready stalls, checker compares records
// *********************************************************************

`include "ttc_trig_defines.svh"

module tb_top;

  import ttc_trig_pkg::*;

  // one golden line
  typedef struct packed {
    logic [7:0]            gap;
    logic [4:0]            trig_type;
    logic [4:0]            chan_en;
    logic                  acq_enable;
    logic [3:0]            alarms;
    logic                  rst_num;
    logic                  rst_ts;
    logic [1:0]            mode;       // rec_ready pattern
    logic                  exp_empty;
    logic [`TTC_NUM_W-1:0] exp_num;
    logic [`TTC_NUM_W-1:0] exp_evt;
    logic                  exp_err;
  } stim_t;

  logic clk = 0;
  logic reset;
  logic ttc_trigger;
  logic [4:0] trig_type;
  logic reset_trig_num;
  logic reset_trig_timestamp;
  logic [4:0] chan_en;
  logic acq_enable;
  logic [3:0] xadc_alarms;
  logic rec_ready;
  logic rec_valid;
  trig_record_t rec_data;
  rx_state_e state;
  logic [`TTC_NUM_W-1:0] trig_num;
  logic [`TTC_TS_W-1:0] trig_timestamp;
  logic error_trig_rate;
  logic readout_done;
  logic [`TTC_NUM_W-1:0] last_trig_num;

  stim_t  stim_q[$];
  logic [1:0] cur_mode = 0;
  longint cycles = 0;
  longint limit = 0;   // 0 until the golden file is read

  always #50 clk = ~clk;

  ttc_trig_top dut_i (.*);

  trig_checker chk_i (
    .clk, .reset, .ttc_trigger, .reset_trig_timestamp,
    .rec_valid, .rec_ready, .rec_data, .state,
    .trig_num, .trig_timestamp,
    .error_trig_rate, .readout_done, .last_trig_num
  );

  // run limit
  always @(posedge clk) begin
    cycles++;
    if (limit != 0 && cycles >= limit) begin
      $display("timeout after %0d cycles, stimulus did not complete", cycles);
      $display("test failed");
      $finish;
    end
  end

  task automatic read_golden();
    int    fd;
    int    n;
    string line;
    int    f[12];
    stim_t s;
    fd = $fopen("verification/trig_golden.txt", "r");
    if (fd == 0) begin
      $display("cannot open verification/trig_golden.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == 8'h23) continue;  // blank or comment
      n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d",
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                  f[8], f[9], f[10], f[11]);
      if (n != 12) continue;
      s.gap        = f[0];
      s.trig_type  = f[1];
      s.chan_en    = f[2];
      s.acq_enable = f[3];
      s.alarms     = f[4];
      s.rst_num    = f[5];
      s.rst_ts     = f[6];
      s.mode       = f[7];
      s.exp_empty  = f[8];
      s.exp_num    = f[9];
      s.exp_evt    = f[10];
      s.exp_err    = f[11];
      stim_q.push_back(s);
      limit += f[0] + 40;  // gap plus slack per line
    end
    $fclose(fd);
  endtask

  // one clock step, pulses cleared, rec_ready per pattern
  task automatic tick();
    @(negedge clk);
    ttc_trigger          = 0;
    reset_trig_num       = 0;
    reset_trig_timestamp = 0;
    case (cur_mode)
      2'd0:    rec_ready = 1;
      2'd1:    rec_ready = 0;
      default: rec_ready = ($urandom % 3) != 0;
    endcase
  endtask

  task automatic run_line(input stim_t s, input bit on_time);
    trig_record_t rec;
    cur_mode = s.mode;
    for (int j = 0; j < s.gap; j++) begin
      tick();
      if (j == s.gap - 1) begin  // Channel-B reset just before trigger
        reset_trig_num       = s.rst_num;
        reset_trig_timestamp = s.rst_ts;
      end
    end
    tick();
    rec             = '0;
    rec.xadc_alarms = s.alarms;
    rec.empty_event = s.exp_empty;
    rec.trig_type   = s.trig_type;
    rec.event_cnt   = s.exp_evt;
    rec.trig_num    = s.exp_num;
    if (s.exp_err) chk_i.expect_error(s.exp_num);
    else           chk_i.add_expect(rec, on_time);
    trig_type   = s.trig_type;
    chan_en     = s.chan_en;
    acq_enable  = s.acq_enable;
    xadc_alarms = s.alarms;
    ttc_trigger = 1;
  endtask

  initial begin
    bit on_time;
    reset                = 1;
    ttc_trigger          = 0;
    trig_type            = 0;
    reset_trig_num       = 0;
    reset_trig_timestamp = 0;
    chan_en              = 0;
    acq_enable           = 0;
    xadc_alarms          = 0;
    rec_ready            = 1;
    void'($urandom(32'h34cc));
    read_golden();
    if (stim_q.size() == 0) limit = 100;  // nothing to run
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 0;
    for (int i = 0; i < stim_q.size(); i++) begin
      // latency only checked when no stall touches the record
      on_time = (stim_q[i].mode == 0) &&
                (i == stim_q.size() - 1 || stim_q[i+1].mode == 0);
      run_line(stim_q[i], on_time);
    end
    cur_mode = 0;
    repeat (40) tick();  // drain and let readouts finish
    chk_i.report();
    if (chk_i.err_cnt == 0 && stim_q.size() != 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- verification/trig_checker.sv
// *********************************************************************
// scoreboard for the TTC trigger subsystem: watches top-level ports,
// compares popped records with expected ones and counts errors
// *********************************************************************

`include "ttc_trig_defines.svh"

module trig_checker (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       ttc_trigger,
  input  logic                       reset_trig_timestamp,
  input  logic                       rec_valid,
  input  logic                       rec_ready,
  input  ttc_trig_pkg::trig_record_t rec_data,
  input  ttc_trig_pkg::rx_state_e    state,
  input  logic [`TTC_NUM_W-1:0]      trig_num,
  input  logic [`TTC_TS_W-1:0]       trig_timestamp,
  input  logic                       error_trig_rate,
  input  logic                       readout_done,
  input  logic [`TTC_NUM_W-1:0]      last_trig_num
);

  import ttc_trig_pkg::*;

  localparam int BUSY = `TTC_ACQ_BUSY_CYCLES;

  trig_record_t exp_q[$];      // expected records, trigger order
  bit           on_time_q[$];  // latency checked for this record
  trig_record_t trig_q[$];     // numbering of every trigger sent
  longint       ts_q[$];       // reference stamp per accepted trigger
  longint       tcyc_q[$];     // cycle of each accepted trigger
  logic [`TTC_NUM_W-1:0] rd_num_q[$];  // readouts in flight
  longint       rd_cyc_q[$];   // cycle each readout must end

  longint cyc;                 // cycles since reset
  longint ts_ref;              // mirror of the stamp counter
  int     err_cnt = 0;
  int     rec_cnt = 0;
  int     done_cnt = 0;        // readout_done pulses seen
  bit     exp_error = 0;       // error trigger sent
  bit     err_seen = 0;
  bit     err_flagged = 0;     // unexpected error reported once
  bit     stat_due = 0;        // status outputs checked next cycle
  logic [`TTC_NUM_W-1:0] stat_num;
  longint stat_ts;

  task automatic add_expect(input trig_record_t rec, input bit on_time);
    exp_q.push_back(rec);
    on_time_q.push_back(on_time);
    trig_q.push_back(rec);
  endtask

  task automatic expect_error(input logic [`TTC_NUM_W-1:0] num);
    trig_record_t rec;
    rec             = '0;
    rec.trig_num    = num;
    rec.empty_event = 1;  // never reaches the channels
    exp_error = 1;
    trig_q.push_back(rec);
  endtask

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  always @(posedge clk) begin
    trig_record_t exp;
    trig_record_t trg;
    longint       ts_exp;
    longint       tcyc;
    bit           on_time;
    if (!reset) begin
      // record leaves toward the trigger processor
      if (rec_valid && rec_ready) begin
        rec_cnt++;
        if (exp_q.size() == 0 || ts_q.size() == 0) begin
          $display("record popped at %0t with no trigger pending", $time);
          err_cnt++;
        end else begin
          exp     = exp_q.pop_front();
          on_time = on_time_q.pop_front();
          ts_exp  = ts_q.pop_front();
          tcyc    = tcyc_q.pop_front();
          check_val("rec_data.reserved", rec_data.reserved, 0);
          check_val("rec_data.empty_payload", rec_data.empty_payload, 0);
          check_val("rec_data.xadc_alarms", rec_data.xadc_alarms, exp.xadc_alarms);
          check_val("rec_data.empty_event", rec_data.empty_event, exp.empty_event);
          check_val("rec_data.trig_type", rec_data.trig_type, exp.trig_type);
          check_val("rec_data.event_cnt", rec_data.event_cnt, exp.event_cnt);
          check_val("rec_data.trig_num", rec_data.trig_num, exp.trig_num);
          check_val("rec_data.timestamp", rec_data.timestamp, ts_exp);
          if (on_time)
            check_val("rec_latency", cyc - tcyc, 3);  // trigger to pop
        end
      end

      // status outputs one cycle after the trigger
      if (stat_due) begin
        check_val("trig_num", trig_num, stat_num);
        check_val("trig_timestamp", trig_timestamp, stat_ts);
        stat_due = 0;
      end

      if (ttc_trigger) begin  // triggers are spaced to land in idle
        check_val("state", state, idle);
        ts_q.push_back(ts_ref);
        tcyc_q.push_back(cyc);
        if (trig_q.size() != 0) begin
          trg      = trig_q.pop_front();
          stat_due = 1;
          stat_num = trg.trig_num + 1'b1;  // next number to hand out
          stat_ts  = ts_ref;
          if (!trg.empty_event) begin
            rd_num_q.push_back(trg.trig_num);
            rd_cyc_q.push_back(cyc + BUSY + 2);  // strobe at T+2, then busy
          end
        end
      end

      if (readout_done) begin
        done_cnt++;
        if (rd_num_q.size() == 0) begin
          $display("readout_done pulsed at %0t with no readout pending", $time);
          err_cnt++;
        end else begin
          check_val("last_trig_num", last_trig_num, rd_num_q.pop_front());
          check_val("readout_done_cycle", cyc, rd_cyc_q.pop_front());
        end
      end

      // error flag sticky and only after the error trigger
      if (error_trig_rate && !exp_error && !err_flagged) begin
        $display("error_trig_rate rose at %0t without a rate violation", $time);
        err_cnt++;
        err_flagged = 1;
      end
      if (err_seen && !error_trig_rate) begin
        $display("error_trig_rate dropped at %0t before reset", $time);
        err_cnt++;
      end
      if (error_trig_rate) err_seen = 1;
    end

    if (reset) cyc = 0;
    else       cyc++;
    if (reset || reset_trig_timestamp) ts_ref = 0;
    else                               ts_ref++;
  end

  // end-of-run checks and the closing counts line
  task automatic report();
    if (exp_q.size() != 0) begin
      $display("%0d expected records never appeared", exp_q.size());
      err_cnt++;
    end
    if (rd_num_q.size() != 0) begin
      $display("%0d readouts never signalled readout_done", rd_num_q.size());
      err_cnt++;
    end
    check_val("error_trig_rate", error_trig_rate, exp_error);
    $display("records: %0d  readouts: %0d  errors: %0d", rec_cnt, done_cnt, err_cnt);
  endtask

endmodule

//--- hw/ttc_trig_top.sv
// *********************************************************************
// TTC trigger subsystem top: receiver, channel controller and
// trigger-info FIFO toward the trigger processor
// *********************************************************************

`include "ttc_trig_defines.svh"

module ttc_trig_top (
  input  logic                       clk,
  input  logic                       reset,
  // TTC side
  input  logic                       ttc_trigger,
  input  logic [4:0]                 trig_type,
  input  logic                       reset_trig_num,
  input  logic                       reset_trig_timestamp,
  // run setup and monitoring
  input  logic [4:0]                 chan_en,
  input  logic                       acq_enable,
  input  logic [3:0]                 xadc_alarms,
  // trigger processor port
  input  logic                       rec_ready,
  output logic                       rec_valid,
  output ttc_trig_pkg::trig_record_t rec_data,
  // status
  output ttc_trig_pkg::rx_state_e    state,
  output logic [`TTC_NUM_W-1:0]      trig_num,
  output logic [`TTC_TS_W-1:0]       trig_timestamp,
  output logic                       error_trig_rate,
  output logic                       readout_done,
  output logic [`TTC_NUM_W-1:0]      last_trig_num
);

  import ttc_trig_pkg::*;

  logic         acq_trigger;    // receiver -> controller strobe
  acq_req_t     acq_req;
  logic         acq_ready;
  logic         acq_activated;
  logic         fifo_valid;     // receiver -> FIFO
  logic         fifo_ready;
  trig_record_t fifo_data;

  ttc_trigger_receiver rx_i (
    .clk, .reset, .reset_trig_num, .reset_trig_timestamp,
    .ttc_trigger, .trig_type, .xadc_alarms,
    .acq_ready, .acq_activated, .acq_trigger, .acq_req,
    .fifo_ready, .fifo_valid, .fifo_data,
    .state, .trig_num, .trig_timestamp, .error_trig_rate
  );

  acq_channel_ctrl acq_i (
    .clk, .reset, .acq_enable, .chan_en,
    .acq_trigger, .acq_req, .acq_ready, .acq_activated,
    .readout_done, .last_trig_num
  );

  trig_info_fifo fifo_i (
    .clk, .reset,
    .wr_valid (fifo_valid), .wr_data (fifo_data), .wr_ready (fifo_ready),
    .rd_valid (rec_valid),  .rd_data (rec_data),  .rd_ready (rec_ready)
  );

endmodule

//--- hw/acq_channel_ctrl.sv
// *********************************************************************
// channel acquisition controller model: takes async readout requests
// and stays busy for a fixed readout time, then reports ready again
// *********************************************************************

`include "ttc_trig_defines.svh"

module acq_channel_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   acq_enable,     // runs armed
  input  logic [4:0]             chan_en,        // enabled channels
  // receiver side
  input  logic                   acq_trigger,    // one-cycle strobe
  input  ttc_trig_pkg::acq_req_t acq_req,
  output logic                   acq_ready,      // not busy
  output logic                   acq_activated,  // armed with a channel on
  // command manager side
  output logic                   readout_done,   // last busy cycle
  output logic [`TTC_NUM_W-1:0]  last_trig_num   // most recent accepted readout
);

  localparam int BUSY = `TTC_ACQ_BUSY_CYCLES;
  localparam int CW   = $clog2(BUSY + 1);

  logic [CW-1:0] busy_cnt;  // cycles left in current readout
  logic          accept;    // strobe taken while idle

  assign acq_ready     = (busy_cnt == '0);
  assign acq_activated = acq_enable && (|chan_en);
  assign accept        = acq_trigger && acq_ready;  // strobe while busy is dropped
  assign readout_done  = (busy_cnt == CW'(1));

  // busy down-counter
  always_ff @(posedge clk) begin
    if (reset) begin
      busy_cnt <= '0;
    end else if (accept) begin
      busy_cnt <= CW'(BUSY);  // low ready from next cycle on
    end else if (busy_cnt != '0) begin
      busy_cnt <= busy_cnt - 1'b1;
    end
  end

  // readout bookkeeping for the command manager
  always_ff @(posedge clk) begin
    if (reset)       last_trig_num <= '0;
    else if (accept) last_trig_num <= acq_req.trig_num;
  end

  // every accepted readout ends exactly BUSY cycles later
  a_done_timing : assert property (
    @(posedge clk) disable iff (reset) accept |-> ##BUSY readout_done
  ) else $error("readout_done not at end of busy time");

  // second strobe inside the busy window, receiver should be erroring
  c_strobe_busy : cover property (
    @(posedge clk) disable iff (reset)
      acq_trigger ##[1:BUSY] (acq_trigger && !acq_ready)
  );

endmodule

//--- hw/trig_info_fifo.sv
// *********************************************************************
// trigger-info FIFO, first-word-fall-through, between the receiver
// and the trigger processor port; depth from the defines header
// *********************************************************************

`include "ttc_trig_defines.svh"

module trig_info_fifo (
  input  logic                       clk,
  input  logic                       reset,
  // write side, receiver
  input  logic                       wr_valid,
  input  ttc_trig_pkg::trig_record_t wr_data,
  output logic                       wr_ready,  // not full
  // read side, trigger processor
  output logic                       rd_valid,  // not empty
  output ttc_trig_pkg::trig_record_t rd_data,   // head entry
  input  logic                       rd_ready
);

  import ttc_trig_pkg::*;

  localparam int DEPTH = `TTC_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  trig_record_t  mem [DEPTH];
  logic [AW-1:0] wr_ptr;   // wraps, depth is a power of two
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;    // occupancy 0..DEPTH
  logic          push;
  logic          pop;

  assign wr_ready = (count != (AW+1)'(DEPTH));
  assign rd_valid = (count != '0);
  assign rd_data  = mem[rd_ptr];
  assign push     = wr_valid && wr_ready;
  assign pop      = rd_valid && rd_ready;

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  // a write while full would land on the unread head
  a_no_overflow : assert property (
    @(posedge clk) disable iff (reset)
      rd_valid && !rd_ready |=> rd_valid && $stable(rd_data)
  ) else $error("trigger FIFO written while full");

  // empty count means the pointers meet
  a_no_underflow : assert property (
    @(posedge clk) disable iff (reset) !rd_valid |-> (rd_ptr == wr_ptr)
  ) else $error("trigger FIFO read while empty");

endmodule

//--- hw/ttc_trigger_receiver.sv
// *********************************************************************
// TTC trigger receiver: numbers and timestamps each trigger, forwards
// async readouts to the channel controller, queues one record per trigger
// *********************************************************************

`include "ttc_trig_defines.svh"

module ttc_trigger_receiver (
  input  logic                       clk,
  input  logic                       reset,
  // Channel-B resets
  input  logic                       reset_trig_num,
  input  logic                       reset_trig_timestamp,
  // trigger input
  input  logic                       ttc_trigger,      // one-cycle pulse
  input  logic [4:0]                 trig_type,
  input  logic [3:0]                 xadc_alarms,
  // channel acquisition controller
  input  logic                       acq_ready,        // controller not busy
  input  logic                       acq_activated,    // runs armed, channels on
  output logic                       acq_trigger,      // one-cycle strobe
  output ttc_trig_pkg::acq_req_t     acq_req,
  // trigger-info FIFO
  input  logic                       fifo_ready,
  output logic                       fifo_valid,
  output ttc_trig_pkg::trig_record_t fifo_data,
  // status
  output ttc_trig_pkg::rx_state_e    state,
  output logic [`TTC_NUM_W-1:0]      trig_num,         // next number to hand out
  output logic [`TTC_TS_W-1:0]       trig_timestamp,   // stamp of last trigger
  output logic                       error_trig_rate
);

  import ttc_trig_pkg::*;

  localparam logic [4:0] ASYNC_TYPE = `TTC_ASYNC_TYPE;

  rx_state_e              state_next;
  logic [`TTC_NUM_W-1:0]  event_cnt;    // accepted readouts, starts at 1
  logic [`TTC_TS_W-1:0]   ts_cnt;       // free-running cycle count
  logic [3:0]             alarms_q;     // alarms latched with the trigger
  logic                   empty_event;  // decided at trigger time
  logic                   take_trig;    // trigger sampled in idle
  logic                   fwd;          // readout goes to the channels
  logic                   to_store;     // send_trigger -> store_trig_info

  assign take_trig = (state == idle) && ttc_trigger;  // busy states drop triggers
  assign to_store  = (state == send_trigger) && acq_ready;
  assign fwd       = to_store && !empty_event;

  // next state
  always_comb begin
    state_next = state;
    case (state)
      idle: begin
        if (ttc_trigger) state_next = send_trigger;
      end
      send_trigger: begin
        // channels still reading out the previous event
        if (!acq_ready) state_next = error;
        else            state_next = store_trig_info;
      end
      store_trig_info: begin
        if (fifo_ready) state_next = idle;  // record taken this cycle
      end
      error: state_next = error;  // hard error, wait for reset
      default: state_next = error;
    endcase
  end

  // control state and counters
  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= idle;
      acq_trigger <= 1'b0;
      empty_event <= 1'b0;
    end else begin
      state       <= state_next;
      acq_trigger <= fwd;  // high in first store_trig_info cycle only
      if (take_trig)
        empty_event <= (trig_type != ASYNC_TYPE) || !acq_activated;
    end

    // numbering restarts at 1
    if (reset || reset_trig_num) begin
      trig_num  <= `TTC_NUM_W'(1);
      event_cnt <= `TTC_NUM_W'(1);
    end else begin
      if (take_trig) trig_num  <= trig_num + 1'b1;
      if (fwd)       event_cnt <= event_cnt + 1'b1;
    end

    // 0 in the first cycle after the reset
    if (reset || reset_trig_timestamp) ts_cnt <= '0;
    else                               ts_cnt <= ts_cnt + 1'b1;

    if (reset)          trig_timestamp <= '0;
    else if (take_trig) trig_timestamp <= ts_cnt;  // count in trigger cycle
  end

  // latched trigger fields
  always_ff @(posedge clk) begin
    if (take_trig) begin
      acq_req.trig_num  <= trig_num;
      acq_req.trig_type <= trig_type;
      alarms_q          <= xadc_alarms;
    end
    // record built once, then held through back-pressure
    if (to_store) begin
      fifo_data.reserved      <= '0;
      fifo_data.empty_payload <= 1'b0;
      fifo_data.xadc_alarms   <= alarms_q;
      fifo_data.empty_event   <= empty_event;
      fifo_data.trig_type     <= acq_req.trig_type;
      fifo_data.event_cnt     <= event_cnt;  // pre-increment value
      fifo_data.trig_num      <= acq_req.trig_num;
      fifo_data.timestamp     <= trig_timestamp;
    end
  end

  assign fifo_valid      = (state == store_trig_info);  // held until transfer
  assign error_trig_rate = (state == error);

  a_state_onehot : assert property (
    @(posedge clk) disable iff (reset) $onehot(state)
  ) else $error("receiver state not one-hot");

  a_strobe_single : assert property (
    @(posedge clk) disable iff (reset) acq_trigger |=> !acq_trigger
  ) else $error("acq_trigger longer than one cycle");

  // record must not move while the FIFO holds it off
  a_record_held : assert property (
    @(posedge clk) disable iff (reset)
      fifo_valid && !fifo_ready |=> fifo_valid && $stable(fifo_data)
  ) else $error("trigger record changed under back-pressure");

endmodule

//--- hw/ttc_trig_pkg.sv
// *********************************************************************
// shared types for the TTC trigger receiver, channel controller and
// trigger-info FIFO; import where the types are used
// *********************************************************************

`include "ttc_trig_defines.svh"

package ttc_trig_pkg;

  // receiver FSM, one-hot
  typedef enum logic [3:0] {
    idle            = 4'b0001,  // waiting for a TTC trigger
    send_trigger    = 4'b0010,  // forward to channels or skip
    store_trig_info = 4'b0100,  // hold record until FIFO takes it
    error           = 4'b1000   // trigger came while channels busy, sticky
  } rx_state_e;

  // one trigger-info FIFO word, 128 bits
  typedef struct packed {
    logic [24:0]            reserved;       // always zero
    logic                   empty_payload;  // self-trigger skip, not used here
    logic [3:0]             xadc_alarms;    // alarms at trigger time
    logic                   empty_event;    // no channel readout for this one
    logic [4:0]             trig_type;
    logic [`TTC_NUM_W-1:0]  event_cnt;      // readouts passed to channels
    logic [`TTC_NUM_W-1:0]  trig_num;
    logic [`TTC_TS_W-1:0]   timestamp;
  } trig_record_t;

  // request sent to the channel controller with acq_trigger
  typedef struct packed {
    logic [4:0]             trig_type;
    logic [`TTC_NUM_W-1:0]  trig_num;
  } acq_req_t;

endpackage

//--- include/ttc_trig_defines.svh
// *********************************************************************
// sizing and code constants for the TTC trigger path
// include wherever FIFO depth, busy time or counter widths are needed
// *********************************************************************

`ifndef TTC_TRIG_DEFINES_SVH
`define TTC_TRIG_DEFINES_SVH

// trigger-info FIFO entries, power of two only
`define TTC_FIFO_DEPTH 8

// cycles the channel controller stays busy per async readout
`define TTC_ACQ_BUSY_CYCLES 12

// trigger type that requests an asynchronous channel readout
`define TTC_ASYNC_TYPE 5'd4

// global trigger number, starts at 1
`define TTC_NUM_W 24

// free-running timestamp, 40 MHz ticks
`define TTC_TS_W 44

`endif
